// ==== build.f ====
periph_pkg.sv
periph_apb_decode.sv
periph_gpio.sv
periph_timer.sv
periph_event_map.sv
soc_periph_top.sv
tb_clk_gen.sv
tb_soc_periph.sv

// ==== run.sh ====
#!/bin/sh
# Compile the RTL and testbench with Verilator, run the simulation
# and pass only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_soc_periph -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_soc_periph)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// ==== tb_soc_periph.sv ====
/*
 * Testbench for the SoC peripheral subsystem
 * Directed tests over the APB port: reset values, GPIO registers and
 * interrupt, reference timer, DMA event pass-through and error response
 */
module tb_soc_periph
    import periph_pkg::*;
();

    localparam int         DRIVE_DELAY  = 2;
    localparam int         SAMPLE_DELAY = 8;
    localparam int         SLOW_HOLD    = 4;
    localparam int         SYNC_WAIT    = 4;
    // All tests take a few hundred cycles
    localparam int         MAX_CYCLES   = 2000;
    localparam logic [31:0] LFSR_SEED   = 32'h146f_7d58;

    localparam logic [3:0] RGN_GPIO  = 4'd0;
    localparam logic [3:0] RGN_TIMER = 4'd1;
    localparam logic [3:0] RGN_EVENT = 4'd2;
    localparam logic [3:0] RGN_BAD   = 4'd5;

    logic       clk;
    logic       arst_n;
    logic       slow_clk;
    apb_addr_t  paddr;
    apb_data_t  pwdata;
    logic       pwrite;
    logic       psel;
    logic       penable;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;
    gpio_t      gpio_in;
    gpio_t      gpio_out;
    gpio_t      gpio_dir;
    logic       dma_pe_evt;
    logic       dma_pe_irq;
    fc_events_t fc_events;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic [31:0] lfsr_state = LFSR_SEED;

    tb_clk_gen u_clk_gen (
        .clk_o    ( clk    ),
        .arst_n_o ( arst_n )
    );

    soc_periph_top u_dut (
        .clk_i        ( clk        ),
        .arst_n_i     ( arst_n     ),
        .slow_clk_i   ( slow_clk   ),
        .paddr_i      ( paddr      ),
        .pwdata_i     ( pwdata     ),
        .pwrite_i     ( pwrite     ),
        .psel_i       ( psel       ),
        .penable_i    ( penable    ),
        .prdata_o     ( prdata     ),
        .pready_o     ( pready     ),
        .pslverr_o    ( pslverr    ),
        .gpio_in_i    ( gpio_in    ),
        .gpio_out_o   ( gpio_out   ),
        .gpio_dir_o   ( gpio_dir   ),
        .dma_pe_evt_i ( dma_pe_evt ),
        .dma_pe_irq_i ( dma_pe_irq ),
        .fc_events_o  ( fc_events  )
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run passed %0d cycles without finishing", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic take_word(output logic [31:0] val);
        val = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};
        end
    endtask

    function automatic apb_addr_t reg_addr(input logic [3:0] region, input reg_off_t off);
        apb_addr_t addr;
        addr                          = '0;
        addr[REGION_MSB:REGION_LSB]   = region;
        addr[3:0]                     = off;
        return addr;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_gpio(input string name, input gpio_t exp, input gpio_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_events(input string name, input fc_events_t exp, input fc_events_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_ready(input string name, input logic ready);
        checks++;
        if (ready !== 1'b1) begin
            errors++;
            $display("%s: pready_o was not high in the access cycle", name);
        end
    endtask

    task automatic check_not_ready(input string name, input logic ready);
        checks++;
        if (ready !== 1'b0) begin
            errors++;
            $display("%s: pready_o was high outside the access cycle", name);
        end
    endtask

    // Entered and left a short delay after a rising edge
    task automatic apb_write(input string name, input apb_addr_t addr, input apb_data_t data);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        #SAMPLE_DELAY;
        check_not_ready(name, pready);
        next_cycle();
        penable = 1'b1;
        #SAMPLE_DELAY;
        check_ready(name, pready);
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data,
                            output logic ready, output logic slverr);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        next_cycle();
        penable = 1'b1;
        #SAMPLE_DELAY;
        data    = prdata;
        ready   = pready;
        slverr  = pslverr;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_expect(input string name, input apb_addr_t addr, input apb_data_t exp);
        apb_data_t data;
        logic      ready;
        logic      slverr;
        apb_read(addr, data, ready, slverr);
        check_ready(name, ready);
        checks++;
        if (slverr !== 1'b0) begin
            errors++;
            $display("%s: pslverr_o was raised on a mapped address %h", name, addr);
        end
        check_data(name, exp, data);
    endtask

    task automatic toggle_slow_clk();
        slow_clk = 1'b1;
        repeat (SLOW_HOLD) next_cycle();
        slow_clk = 1'b0;
        repeat (SLOW_HOLD) next_cycle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        read_expect("reset gpio dir", reg_addr(RGN_GPIO, GPIO_DIR_OFF), '0);
        read_expect("reset gpio out", reg_addr(RGN_GPIO, GPIO_OUT_OFF), '0);
        read_expect("reset gpio in", reg_addr(RGN_GPIO, GPIO_IN_OFF), '0);
        read_expect("reset gpio irq_en", reg_addr(RGN_GPIO, GPIO_IRQ_EN_OFF), '0);
        read_expect("reset timer ctrl", reg_addr(RGN_TIMER, TIMER_CTRL_OFF), '0);
        read_expect("reset timer cmp", reg_addr(RGN_TIMER, TIMER_CMP_OFF), '0);
        read_expect("reset timer count", reg_addr(RGN_TIMER, TIMER_COUNT_OFF), '0);
        read_expect("reset pending", reg_addr(RGN_EVENT, EVENT_PENDING_OFF), '0);
        check_gpio("reset gpio_dir_o", '0, gpio_dir);
        check_gpio("reset gpio_out_o", '0, gpio_out);
        check_events("reset fc_events_o", '0, fc_events);
    endtask

    task automatic test_gpio_regs();
        logic [31:0] dir_val;
        logic [31:0] out_val;
        logic [31:0] junk;
        take_word(dir_val);
        take_word(out_val);
        take_word(junk);
        apb_write("gpio dir write", reg_addr(RGN_GPIO, GPIO_DIR_OFF), dir_val);
        apb_write("gpio out write", reg_addr(RGN_GPIO, GPIO_OUT_OFF), out_val);
        read_expect("gpio dir readback", reg_addr(RGN_GPIO, GPIO_DIR_OFF), dir_val);
        read_expect("gpio out readback", reg_addr(RGN_GPIO, GPIO_OUT_OFF), out_val);
        check_gpio("gpio_dir_o", dir_val, gpio_dir);
        check_gpio("gpio_out_o", out_val, gpio_out);
        // IN is read only and follows the pins, still all low
        apb_write("gpio in write", reg_addr(RGN_GPIO, GPIO_IN_OFF), junk);
        read_expect("gpio in after write", reg_addr(RGN_GPIO, GPIO_IN_OFF), '0);
        read_expect("gpio dir after in write", reg_addr(RGN_GPIO, GPIO_DIR_OFF), dir_val);
        read_expect("gpio out after in write", reg_addr(RGN_GPIO, GPIO_OUT_OFF), out_val);
        read_expect("gpio irq_en after in write", reg_addr(RGN_GPIO, GPIO_IRQ_EN_OFF), '0);
    endtask

    task automatic test_gpio_irq();
        logic [31:0] in_val;
        gpio_t       en_bit;
        gpio_t       off_bit;
        take_word(in_val);
        en_bit  = gpio_t'(1) << 3;
        off_bit = gpio_t'(1) << 20;
        gpio_in = in_val;
        repeat (SYNC_WAIT) next_cycle();
        read_expect("gpio in sampled", reg_addr(RGN_GPIO, GPIO_IN_OFF), in_val);
        gpio_in = '0;
        repeat (SYNC_WAIT) next_cycle();
        apb_write("gpio irq_en write", reg_addr(RGN_GPIO, GPIO_IRQ_EN_OFF), en_bit);
        apb_write("pending clear all", reg_addr(RGN_EVENT, EVENT_PENDING_OFF), '1);
        gpio_in = en_bit;
        repeat (SYNC_WAIT) next_cycle();
        read_expect("gpio event pending", reg_addr(RGN_EVENT, EVENT_PENDING_OFF),
                    apb_data_t'(1) << EVT_GPIO);
        apb_write("gpio pending clear", reg_addr(RGN_EVENT, EVENT_PENDING_OFF),
                  apb_data_t'(1) << EVT_GPIO);
        read_expect("gpio pending cleared", reg_addr(RGN_EVENT, EVENT_PENDING_OFF), '0);
        // Disabled line rises, enabled line stays high
        gpio_in = en_bit | off_bit;
        repeat (SYNC_WAIT) next_cycle();
        read_expect("gpio disabled edge", reg_addr(RGN_EVENT, EVENT_PENDING_OFF), '0);
    endtask

    task automatic test_timer();
        apb_write("pending clear all", reg_addr(RGN_EVENT, EVENT_PENDING_OFF), '1);
        apb_write("timer cmp write", reg_addr(RGN_TIMER, TIMER_CMP_OFF), 32'd3);
        apb_write("timer enable", reg_addr(RGN_TIMER, TIMER_CTRL_OFF), 32'd1);
        toggle_slow_clk();
        toggle_slow_clk();
        read_expect("timer count after 2", reg_addr(RGN_TIMER, TIMER_COUNT_OFF), 32'd2);
        read_expect("timer pending after 2", reg_addr(RGN_EVENT, EVENT_PENDING_OFF),
                    apb_data_t'(1) << EVT_REF_EDGE);
        toggle_slow_clk();
        read_expect("timer count wrapped", reg_addr(RGN_TIMER, TIMER_COUNT_OFF), '0);
        read_expect("timer pending after 3", reg_addr(RGN_EVENT, EVENT_PENDING_OFF),
                    (apb_data_t'(1) << EVT_TIMER_LO) | (apb_data_t'(1) << EVT_REF_EDGE));
    endtask

    task automatic test_dma_and_error();
        fc_events_t exp;
        apb_data_t  data;
        logic       ready;
        logic       slverr;
        exp              = '0;
        exp[EVT_DMA_PE]  = 1'b1;
        exp[EVT_DMA_IRQ] = 1'b1;
        apb_write("pending clear all", reg_addr(RGN_EVENT, EVENT_PENDING_OFF), '1);
        dma_pe_evt = 1'b1;
        dma_pe_irq = 1'b1;
        next_cycle();
        dma_pe_evt = 1'b0;
        dma_pe_irq = 1'b0;
        #SAMPLE_DELAY;
        check_events("dma events one cycle later", exp, fc_events);
        next_cycle();
        #SAMPLE_DELAY;
        check_events("dma events gone", '0, fc_events);
        next_cycle();
        read_expect("dma pending", reg_addr(RGN_EVENT, EVENT_PENDING_OFF), exp);
        apb_read(reg_addr(RGN_BAD, 4'h0), data, ready, slverr);
        check_ready("unmapped read", ready);
        checks++;
        if (slverr !== 1'b1) begin
            errors++;
            $display("unmapped read: pslverr_o stayed low for region 5");
        end
        check_data("unmapped read data", '0, data);
    endtask

    initial begin
        slow_clk   = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        pwrite     = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        gpio_in    = '0;
        dma_pe_evt = 1'b0;
        dma_pe_irq = 1'b0;
        wait (arst_n === 1'b1);
        next_cycle();
        test_reset_state();
        test_gpio_regs();
        test_gpio_irq();
        test_timer();
        test_dma_and_error();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tb_clk_gen.sv ====
/*
 * Testbench clock and reset
 * 20 unit clock period, reset held low for the first 5 cycles
 */
module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release shortly after an edge, like the other stimulus
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        arst_n_o = 1'b1;
    end

endmodule

// ==== soc_periph_top.sv ====
/*
 * SoC peripheral subsystem
 * APB slave port decoded into GPIO, reference timer and fc event mapper
 */
module soc_periph_top
    import periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       slow_clk_i,

    input  apb_addr_t  paddr_i,
    input  apb_data_t  pwdata_i,
    input  logic       pwrite_i,
    input  logic       psel_i,
    input  logic       penable_i,
    output apb_data_t  prdata_o,
    output logic       pready_o,
    output logic       pslverr_o,

    input  gpio_t      gpio_in_i,
    output gpio_t      gpio_out_o,
    output gpio_t      gpio_dir_o,

    input  logic       dma_pe_evt_i,
    input  logic       dma_pe_irq_i,
    output fc_events_t fc_events_o
);

    logic      gpio_sel;
    logic      timer_sel;
    logic      event_sel;
    logic      wr;
    reg_off_t  reg_off;
    apb_data_t wdata;

    apb_data_t gpio_rdata;
    apb_data_t timer_rdata;
    apb_data_t event_rdata;

    logic      gpio_event;
    logic      timer_irq;
    logic      ref_edge;

    ////////////////////////////////////////////////////////////////////////////
    // Bus decode
    ////////////////////////////////////////////////////////////////////////////

    periph_apb_decode u_decode (
        .paddr_i       ( paddr_i     ),
        .pwdata_i      ( pwdata_i    ),
        .pwrite_i      ( pwrite_i    ),
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   ),
        .gpio_rdata_i  ( gpio_rdata  ),
        .timer_rdata_i ( timer_rdata ),
        .event_rdata_i ( event_rdata ),
        .gpio_sel_o    ( gpio_sel    ),
        .timer_sel_o   ( timer_sel   ),
        .event_sel_o   ( event_sel   ),
        .wr_o          ( wr          ),
        .reg_off_o     ( reg_off     ),
        .wdata_o       ( wdata       )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Peripherals
    ////////////////////////////////////////////////////////////////////////////

    periph_gpio u_gpio (
        .clk_i      ( clk_i      ),
        .arst_n_i   ( arst_n_i   ),
        .sel_i      ( gpio_sel   ),
        .wr_i       ( wr         ),
        .reg_off_i  ( reg_off    ),
        .wdata_i    ( wdata      ),
        .rdata_o    ( gpio_rdata ),
        .gpio_in_i  ( gpio_in_i  ),
        .gpio_out_o ( gpio_out_o ),
        .gpio_dir_o ( gpio_dir_o ),
        .event_o    ( gpio_event )
    );

    periph_timer u_timer (
        .clk_i      ( clk_i       ),
        .arst_n_i   ( arst_n_i    ),
        .sel_i      ( timer_sel   ),
        .wr_i       ( wr          ),
        .reg_off_i  ( reg_off     ),
        .wdata_i    ( wdata       ),
        .rdata_o    ( timer_rdata ),
        .slow_clk_i ( slow_clk_i  ),
        .irq_lo_o   ( timer_irq   ),
        .ref_edge_o ( ref_edge    )
    );

    periph_event_map u_event_map (
        .clk_i        ( clk_i        ),
        .arst_n_i     ( arst_n_i     ),
        .sel_i        ( event_sel    ),
        .wr_i         ( wr           ),
        .reg_off_i    ( reg_off      ),
        .wdata_i      ( wdata        ),
        .rdata_o      ( event_rdata  ),
        .gpio_event_i ( gpio_event   ),
        .timer_irq_i  ( timer_irq    ),
        .ref_edge_i   ( ref_edge     ),
        .dma_pe_evt_i ( dma_pe_evt_i ),
        .dma_pe_irq_i ( dma_pe_irq_i ),
        .fc_events_o  ( fc_events_o  )
    );

endmodule

// ==== periph_event_map.sv ====
/*
 * fc event mapper
 * Places the peripheral events at their fixed bits, registers the vector
 * and keeps a pending copy that is cleared by writing ones
 */
module periph_event_map
    import periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,

    input  logic       sel_i,
    input  logic       wr_i,
    input  reg_off_t   reg_off_i,
    input  apb_data_t  wdata_i,
    output apb_data_t  rdata_o,

    input  logic       gpio_event_i,
    input  logic       timer_irq_i,
    input  logic       ref_edge_i,
    input  logic       dma_pe_evt_i,
    input  logic       dma_pe_irq_i,
    output fc_events_t fc_events_o
);

    fc_events_t events_d;
    fc_events_t events_q;
    fc_events_t pending_q;
    fc_events_t clr_mask;

    // Unused positions stay at zero
    always_comb begin
        events_d               = '0;
        events_d[EVT_DMA_PE]   = dma_pe_evt_i;
        events_d[EVT_DMA_IRQ]  = dma_pe_irq_i;
        events_d[EVT_TIMER_LO] = timer_irq_i;
        events_d[EVT_REF_EDGE] = ref_edge_i;
        events_d[EVT_GPIO]     = gpio_event_i;
    end

    assign clr_mask = (sel_i && wr_i && reg_off_i == EVENT_PENDING_OFF) ? wdata_i : '0;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            events_q  <= '0;
            pending_q <= '0;
        end else begin
            events_q  <= events_d;
            // A new event wins over a clear in the same cycle
            pending_q <= (pending_q & ~clr_mask) | events_d;
        end
    end

    assign fc_events_o = events_q;
    assign rdata_o     = (sel_i && reg_off_i == EVENT_PENDING_OFF) ? pending_q : '0;

endmodule

// ==== periph_timer.sv ====
/*
 * Reference tick timer
 * Synchronizes the slow reference clock, flags both of its edges and
 * counts rising edges up to a compare value that raises the low interrupt
 */
module periph_timer
    import periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,

    input  logic      sel_i,
    input  logic      wr_i,
    input  reg_off_t  reg_off_i,
    input  apb_data_t wdata_i,
    output apb_data_t rdata_o,

    input  logic      slow_clk_i,
    output logic      irq_lo_o,
    output logic      ref_edge_o
);

    logic      slow_meta_q;
    logic      slow_sync_q;
    logic      slow_prev_q;
    logic      slow_rise;

    logic      en_q;
    apb_data_t cmp_q;
    apb_data_t count_q;
    apb_data_t count_inc;
    logic      irq_q;
    logic      ctrl_wr;

    ////////////////////////////////////////////////////////////////////////////
    // Slow clock synchronizer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slow_meta_q <= 1'b0;
            slow_sync_q <= 1'b0;
            slow_prev_q <= 1'b0;
        end else begin
            slow_meta_q <= slow_clk_i;
            slow_sync_q <= slow_meta_q;
            slow_prev_q <= slow_sync_q;
        end
    end

    assign slow_rise  = slow_sync_q & ~slow_prev_q;
    assign ref_edge_o = slow_sync_q ^ slow_prev_q;

    ////////////////////////////////////////////////////////////////////////////
    // Registers and counter
    ////////////////////////////////////////////////////////////////////////////

    assign ctrl_wr   = sel_i & wr_i & (reg_off_i == TIMER_CTRL_OFF);
    assign count_inc = count_q + 1'b1;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_q    <= 1'b0;
            cmp_q   <= '0;
            count_q <= '0;
            irq_q   <= 1'b0;
        end else begin
            irq_q <= 1'b0;
            if (sel_i && wr_i && reg_off_i == TIMER_CMP_OFF) begin
                cmp_q <= wdata_i;
            end
            if (ctrl_wr) begin
                // Restart counting from zero on any CTRL write
                en_q    <= wdata_i[TIMER_EN_BIT];
                count_q <= '0;
            end else if (en_q && slow_rise) begin
                if (count_inc == cmp_q) begin
                    count_q <= '0;
                    irq_q   <= 1'b1;
                end else begin
                    count_q <= count_inc;
                end
            end
        end
    end

    assign irq_lo_o = irq_q;

    always_comb begin
        rdata_o = '0;
        if (sel_i) begin
            case (reg_off_i)
                TIMER_CTRL_OFF:  rdata_o[TIMER_EN_BIT] = en_q;
                TIMER_CMP_OFF:   rdata_o = cmp_q;
                TIMER_COUNT_OFF: rdata_o = count_q;
                default:         rdata_o = '0;
            endcase
        end
    end

endmodule

// ==== periph_gpio.sv ====
/*
 * GPIO block
 * Direction, output and interrupt enable registers, a two-flop input
 * synchronizer and a rising-edge event on the enabled lines
 */
module periph_gpio
    import periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,

    input  logic      sel_i,
    input  logic      wr_i,
    input  reg_off_t  reg_off_i,
    input  apb_data_t wdata_i,
    output apb_data_t rdata_o,

    input  gpio_t     gpio_in_i,
    output gpio_t     gpio_out_o,
    output gpio_t     gpio_dir_o,
    output logic      event_o
);

    gpio_t dir_q;
    gpio_t out_q;
    gpio_t irq_en_q;

    gpio_t in_meta_q;
    gpio_t in_sync_q;
    gpio_t in_prev_q;

    logic  reg_wr;

    assign reg_wr = sel_i & wr_i;

    ////////////////////////////////////////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dir_q    <= '0;
            out_q    <= '0;
            irq_en_q <= '0;
        end else if (reg_wr) begin
            case (reg_off_i)
                GPIO_DIR_OFF:    dir_q    <= wdata_i;
                GPIO_OUT_OFF:    out_q    <= wdata_i;
                GPIO_IRQ_EN_OFF: irq_en_q <= wdata_i;
                default:         ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Input synchronizer and edge detect
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
            in_prev_q <= '0;
        end else begin
            in_meta_q <= gpio_in_i;
            in_sync_q <= in_meta_q;
            in_prev_q <= in_sync_q;
        end
    end

    // One cycle pulse when any enabled line rises
    assign event_o = |(in_sync_q & ~in_prev_q & irq_en_q);

    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;

    always_comb begin
        rdata_o = '0;
        if (sel_i) begin
            case (reg_off_i)
                GPIO_DIR_OFF:    rdata_o = dir_q;
                GPIO_OUT_OFF:    rdata_o = out_q;
                GPIO_IN_OFF:     rdata_o = in_sync_q;
                GPIO_IRQ_EN_OFF: rdata_o = irq_en_q;
                default:         rdata_o = '0;
            endcase
        end
    end

endmodule

// ==== periph_apb_decode.sv ====
/*
 * APB region decode
 * Splits the slave port into the GPIO, timer and event regions,
 * forms the write strobe and muxes the read data back
 */
module periph_apb_decode
    import periph_pkg::*;
(
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    input  logic      pwrite_i,
    input  logic      psel_i,
    input  logic      penable_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,

    input  apb_data_t gpio_rdata_i,
    input  apb_data_t timer_rdata_i,
    input  apb_data_t event_rdata_i,
    output logic      gpio_sel_o,
    output logic      timer_sel_o,
    output logic      event_sel_o,
    output logic      wr_o,
    output reg_off_t  reg_off_o,
    output apb_data_t wdata_o
);

    periph_region_e region;
    logic           access;

    always_comb begin
        case (paddr_i[REGION_MSB:REGION_LSB])
            4'd0:    region = REGION_GPIO;
            4'd1:    region = REGION_TIMER;
            4'd2:    region = REGION_EVENT;
            default: region = REGION_NONE;
        endcase
    end

    // Access phase of a transfer, no wait states
    assign access   = psel_i & penable_i;
    assign pready_o = access;
    assign wr_o     = access & pwrite_i;

    assign gpio_sel_o  = psel_i & (region == REGION_GPIO);
    assign timer_sel_o = psel_i & (region == REGION_TIMER);
    assign event_sel_o = psel_i & (region == REGION_EVENT);

    assign reg_off_o = paddr_i[3:0];
    assign wdata_o   = pwdata_i;

    // Unmapped region answers with an error and zero data
    assign pslverr_o = access & (region == REGION_NONE);

    always_comb begin
        case (region)
            REGION_GPIO:  prdata_o = gpio_rdata_i;
            REGION_TIMER: prdata_o = timer_rdata_i;
            REGION_EVENT: prdata_o = event_rdata_i;
            default:      prdata_o = '0;
        endcase
    end

endmodule

// ==== periph_pkg.sv ====
/*
 * Peripheral subsystem package
 * Bus widths, shared vector types, region decode, register offsets
 * and the fixed positions of the fc event vector
 */
package periph_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and types
    ////////////////////////////////////////////////////////////////////////////

    localparam int APB_ADDR_WIDTH = 32;
    localparam int APB_DATA_WIDTH = 32;
    localparam int NGPIO          = 32;
    localparam int NB_FC_EVENTS   = 32;

    typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;
    typedef logic [NGPIO-1:0]          gpio_t;
    typedef logic [NB_FC_EVENTS-1:0]   fc_events_t;

    // Byte offset inside one peripheral region
    typedef logic [3:0] reg_off_t;

    ////////////////////////////////////////////////////////////////////////////
    // Region decode
    ////////////////////////////////////////////////////////////////////////////

    localparam int REGION_MSB = 15;
    localparam int REGION_LSB = 12;

    typedef enum logic [1:0] {
        REGION_GPIO  = 2'd0,
        REGION_TIMER = 2'd1,
        REGION_EVENT = 2'd2,
        REGION_NONE  = 2'd3
    } periph_region_e;

    ////////////////////////////////////////////////////////////////////////////
    // Register offsets
    ////////////////////////////////////////////////////////////////////////////

    localparam reg_off_t GPIO_DIR_OFF    = 4'h0;
    localparam reg_off_t GPIO_OUT_OFF    = 4'h4;
    localparam reg_off_t GPIO_IN_OFF     = 4'h8;
    localparam reg_off_t GPIO_IRQ_EN_OFF = 4'hC;

    localparam reg_off_t TIMER_CTRL_OFF  = 4'h0;
    localparam reg_off_t TIMER_CMP_OFF   = 4'h4;
    localparam reg_off_t TIMER_COUNT_OFF = 4'h8;

    // Enable bit inside the timer CTRL register
    localparam int TIMER_EN_BIT = 0;

    localparam reg_off_t EVENT_PENDING_OFF = 4'h0;

    ////////////////////////////////////////////////////////////////////////////
    // Event positions in the fc event vector
    ////////////////////////////////////////////////////////////////////////////

    localparam int EVT_DMA_PE   = 8;
    localparam int EVT_DMA_IRQ  = 9;
    localparam int EVT_TIMER_LO = 10;
    localparam int EVT_REF_EDGE = 14;
    localparam int EVT_GPIO     = 15;

endpackage
